// ==== verilog.f ====
verilog/memPkg.sv
verilog/cycleDecode.sv
verilog/wordSequencer.sv
verilog/coreArray.sv
verilog/readReturn.sv
verilog/mb20Memory.sv
verification/memBus_sva.sv
verification/mb20Tb.sv

// ==== Makefile ====
# Verilator build and run for the MB20 memory testbench

VERILATOR ?= verilator
TOP       ?= mb20Tb
FILELIST  ?= verilog.f
OBJDIR    ?= obj_dir
JOBS      ?= 4
VFLAGS    ?= --binary --timing --assert -j $(JOBS)
PASS_MSG  ?= ** PASS **

SIM := $(OBJDIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)

# Status comes from the pass line in the simulator output
run: compile
	@out="$$($(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJDIR)

// ==== verification/mb20Tb.sv ====
// Testbench for the MB20 core memory slave
// Random write and read quads checked against a word model of the core

`timescale 1ns/1ps

module mb20Tb
  import memPkg::*;
();

  // Small core so that random quads land on each other
  localparam int memWords = 64;
  localparam int idxBits = $clog2(memWords);
  localparam int nPairs = 24;
  localparam int numCycles = 2 * nPairs + 6;
  localparam int timeoutLimit = numCycles * 6 + 200;

  typedef logic [idxBits-1:0] tIdx;

  logic    mbus;
  logic    reset;
  logic    start;
  logic    rdRq;
  logic    wrRq;
  tRqMask  rq;
  tMemAddr adr;
  tWord36  dOut;
  logic    validOut;
  logic    ackn;
  logic    validIn;
  tWord36  dIn;
  logic    parIn;

  // Word model and read words still on their way
  tWord36 model [memWords];
  tWord36 expQ [$];

  int checks = 0;
  int errors = 0;
  int acknTotal = 0;
  int expAcknTotal = 0;
  int cycleCount = 0;

  mb20Memory #(.memWords(memWords)) uut (
    .mbus(mbus), .reset(reset), .start(start), .rdRq(rdRq), .wrRq(wrRq),
    .rq(rq), .adr(adr), .dOut(dOut), .validOut(validOut),
    .ackn(ackn), .validIn(validIn), .dIn(dIn), .parIn(parIn)
  );

  always #4 mbus = ~mbus;

  task automatic compareBit(string name, logic expv, logic actv);
    checks++;
    assert (expv === actv) else begin
      errors++;
      $display("mismatch at %0t: %s expected %b got %b", $time, name, expv, actv);
    end
  endtask

  task automatic compareWord(string name, tWord36 expv, tWord36 actv);
    checks++;
    assert (expv === actv) else begin
      errors++;
      $display("mismatch at %0t: %s expected %h got %h", $time, name, expv, actv);
    end
  endtask

  task automatic compareCount(string name, int expv, int actv);
    checks++;
    assert (expv == actv) else begin
      errors++;
      $display("mismatch at %0t: %s expected %0d got %0d", $time, name, expv, actv);
    end
  endtask

  task automatic expectTrue(logic ok, string what);
    checks++;
    assert (ok) else begin
      errors++;
      $display("error at %0t: %s", $time, what);
    end
  endtask

  // Slot k address, index stepping within the aligned quad
  function automatic tMemAddr wrapAddr(tMemAddr a, int k);
    tMemAddr r;
    r = a;
    r[1:0] = a[1:0] + 2'(k);
    return r;
  endfunction

  // Core index, address modulo memWords
  function automatic tIdx modelIdx(tMemAddr a);
    return a[idxBits-1:0];
  endfunction

  function automatic tWord36 randWord();
    logic [63:0] r;
    r = {$urandom(), $urandom()};
    return r[35:0];
  endfunction

  // Inputs change 1 ns after the rising edge
  task automatic nextCycle();
    @(posedge mbus);
    #1;
  endtask

  // One bus cycle: start in this cycle, slots 0 to 3, then the last write word
  // Qualifier {wrRq, rdRq}
  task automatic runCycle(logic [1:0] qual, tMemAddr a, tRqMask m, logic busyStart);
    logic accepted;
    logic isWr;
    logic expAckn;
    accepted = (qual == 2'b01) || (qual == 2'b10);
    isWr = qual[1];
    compareBit("ackn", 1'b0, ackn);
    start = 1'b1;
    rdRq = qual[0];
    wrRq = qual[1];
    rq = m;
    adr = a;
    if (accepted) begin
      expAcknTotal += $countones(m);
    end
    for (int k = 0; k < 5; k++) begin
      nextCycle();
      expAckn = 1'b0;
      if (k < 4) begin
        expAckn = accepted && m[2'(k)];
      end
      compareBit("ackn", expAckn, ackn);
      start = 1'b0;
      rdRq = 1'b0;
      wrRq = 1'b0;
      rq = '0;
      adr = '0;
      dOut = randWord();
      // Stray validOut with no pending write must not write
      validOut = 1'($urandom % 2);
      if (k > 0 && isWr && accepted) begin
        if (m[2'(k - 1)]) begin
          // Word for the slot acknowledged last cycle, sometimes withheld
          validOut = ($urandom % 4) != 0;
          if (validOut) begin
            model[modelIdx(wrapAddr(a, k - 1))] = dOut;
          end
        end
      end
      if (expAckn && !isWr) begin
        expQ.push_back(model[modelIdx(wrapAddr(a, k))]);
      end
      // Start while busy, dropped by the decoder
      if (busyStart && k == 1) begin
        start = 1'b1;
        rdRq = 1'b1;
        rq = 4'hf;
        adr = tMemAddr'($urandom);
      end
    end
  endtask

  // Read word monitor and ackn counter, sampled mid cycle
  always @(negedge mbus) begin : readMonitor
    tWord36 expW;
    if (!reset && ackn === 1'b1) begin
      acknTotal++;
    end
    if (!reset && validIn === 1'b1) begin
      if (expQ.size() == 0) begin
        expectTrue(1'b0, "validIn high with no read outstanding");
      end else begin
        expW = expQ.pop_front();
        compareWord("dIn", expW, dIn);
        // 37 bits odd, so parity is set when the word has an even count of ones
        compareBit("parIn", ($countones(expW) % 2) == 0, parIn);
      end
    end
  end

  always @(posedge mbus) begin : watchdog
    cycleCount++;
    if (cycleCount > timeoutLimit) begin
      $display("timeout after %0d cycles, the run did not finish", cycleCount);
      $display("** FAIL **");
      $finish;
    end
  end

  initial begin
    tMemAddr a;
    tRqMask  m;
    int      svaErrors;
    void'($urandom(44864));
    mbus = 1'b0;
    reset = 1'b1;
    start = 1'b0;
    rdRq = 1'b0;
    wrRq = 1'b0;
    rq = '0;
    adr = '0;
    dOut = '0;
    validOut = 1'b0;
    for (int i = 0; i < memWords; i++) begin
      model[i] = '0;
    end
    // Bus stays quiet through reset
    for (int i = 0; i < 16; i++) begin
      nextCycle();
      compareBit("ackn", 1'b0, ackn);
      compareBit("validIn", 1'b0, validIn);
    end
    reset = 1'b0;
    nextCycle();
    // Write a random mask, then read the whole quad back
    for (int i = 0; i < nPairs; i++) begin
      a = tMemAddr'($urandom);
      m = tRqMask'($urandom);
      runCycle(2'b10, a, m, i % 3 == 0);
      runCycle(2'b01, a, 4'hf, i % 4 == 1);
    end
    // Bad qualifiers and empty masks
    runCycle(2'b11, tMemAddr'($urandom), 4'hf, 1'b0);
    runCycle(2'b00, tMemAddr'($urandom), 4'hf, 1'b0);
    runCycle(2'b10, tMemAddr'($urandom), 4'h0, 1'b0);
    runCycle(2'b01, tMemAddr'($urandom), 4'h0, 1'b0);
    // Partial reads from a random start index
    runCycle(2'b01, tMemAddr'($urandom), tRqMask'($urandom), 1'b1);
    runCycle(2'b01, tMemAddr'($urandom), tRqMask'($urandom), 1'b0);
    validOut = 1'b0;
    while (expQ.size() != 0) begin
      nextCycle();
    end
    repeat (4) begin
      nextCycle();
      compareBit("ackn", 1'b0, ackn);
      compareBit("validIn", 1'b0, validIn);
    end
    compareCount("ackn total", expAcknTotal, acknTotal);
    // Protocol assertions in the bound checker
    svaErrors = uut.busChecks.failCount;
    $display("checks %0d, errors %0d, bus assertion failures %0d",
             checks, errors, svaErrors);
    if (errors == 0 && svaErrors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// ==== verification/memBus_sva.sv ====
// Bus protocol checks for the MB20 memory
// Bound to the top level, reports through concurrent assertions

`timescale 1ns/1ps

module memBusChecks
  import memPkg::*;
(
  input logic      mbus,
  input logic      reset,
  input logic      start,
  input logic      rdRq,
  input logic      wrRq,
  input logic      ackn,
  input logic      validIn,
  input tWord36    dIn,
  input logic      parIn,
  input tCycleDesc desc,
  input logic      done
);

  // Read word acknowledged this cycle
  logic readAck;

  // Ackn pulses seen so far in the running cycle
  logic [2:0] acknSeen;

  // Slot cycles still to run, tracked from the bus start
  logic [2:0] slotsLeft;

  // Failed assertions, picked up by the testbench at the end
  int failCount = 0;

  always_comb begin
    readAck = ackn && !desc.isWrite;
  end

  always_ff @(posedge mbus) begin
    if (reset || done) begin
      acknSeen <= 3'd0;
    end else if (ackn) begin
      acknSeen <= acknSeen + 3'd1;
    end
  end

  // Four slots follow a start with exactly one qualifier
  // Starts during those slots are ignored
  always_ff @(posedge mbus) begin
    if (reset) begin
      slotsLeft <= 3'd0;
    end else if (slotsLeft != 3'd0) begin
      slotsLeft <= slotsLeft - 3'd1;
    end else if (start && (rdRq != wrRq)) begin
      slotsLeft <= 3'd4;
    end
  end

  // Ackn and validIn low once reset has been seen
  resetQuiet: assert property (@(posedge mbus) $past(reset) |-> (!ackn && !validIn))
    else begin
      failCount++;
      $error("ackn or validIn high after a reset cycle");
    end

  // No ackn outside the four slots after an accepted start
  acknInCycle: assert property (@(posedge mbus) disable iff (reset)
    ackn |-> (slotsLeft != 3'd0))
    else begin
      failCount++;
      $error("ackn with no cycle running");
    end

  // One ackn per set mask bit, totalled at slot 3
  acknCount: assert property (@(posedge mbus) disable iff (reset)
    done |-> ((acknSeen + {2'b00, ackn}) == 3'($countones(desc.rq))))
    else begin
      failCount++;
      $error("ackn count differs from the request mask");
    end

  // Read word two cycles after its ackn, and at no other time
  readLatency: assert property (@(posedge mbus) disable iff (reset)
    validIn == $past(readAck, 2))
    else begin
      failCount++;
      $error("validIn not two cycles after a read ackn");
    end

  // Odd parity over dIn and parIn
  parityOdd: assert property (@(posedge mbus) disable iff (reset)
    validIn |-> (^{dIn, parIn}))
    else begin
      failCount++;
      $error("even parity on a returned word");
    end

endmodule

bind mb20Memory memBusChecks busChecks (
  .mbus(mbus), .reset(reset), .start(start), .rdRq(rdRq), .wrRq(wrRq),
  .ackn(ackn), .validIn(validIn), .dIn(dIn), .parIn(parIn), .desc(desc),
  .done(done)
);

// ==== verilog/mb20Memory.sv ====
// MB20 core memory slave
// Decode, word sequencer, core array and read return on one bus clock

`timescale 1ns/1ps

module mb20Memory
  import memPkg::*;
#(
  parameter int memWords = 4096
) (
  input  logic    mbus,
  input  logic    reset,
  input  logic    start,
  input  logic    rdRq,
  input  logic    wrRq,
  input  tRqMask  rq,
  input  tMemAddr adr,
  input  tWord36  dOut,
  input  logic    validOut,
  output logic    ackn,
  output logic    validIn,
  output tWord36  dIn,
  output logic    parIn
);

  tCycleDesc desc;
  logic      done;
  tArrayOp   op;
  logic      readTag;
  tWord36    rdData;

  // Decode stage
  cycleDecode decode (
    .mbus(mbus), .reset(reset), .start(start), .rdRq(rdRq), .wrRq(wrRq),
    .rq(rq), .adr(adr), .done(done), .desc(desc)
  );

  // Execute stage
  wordSequencer sequencer (
    .mbus(mbus), .reset(reset), .desc(desc), .dOut(dOut), .validOut(validOut),
    .ackn(ackn), .op(op), .readTag(readTag), .done(done)
  );

  coreArray #(.memWords(memWords)) array (
    .mbus(mbus), .op(op), .rdData(rdData)
  );

  // Result stage
  readReturn result (
    .mbus(mbus), .reset(reset), .readTag(readTag), .rdData(rdData),
    .validIn(validIn), .dIn(dIn), .parIn(parIn)
  );

endmodule

// ==== verilog/readReturn.sv ====
// Read return path for the MB20 memory
// Puts tagged array words on the bus with validIn and odd parity

`timescale 1ns/1ps

module readReturn
  import memPkg::*;
(
  input  logic   mbus,
  input  logic   reset,
  input  logic   readTag,
  input  tWord36 rdData,
  output logic   validIn,
  output tWord36 dIn,
  output logic   parIn
);

  // Parity of the word now leaving the array
  logic rdPar;

  always_comb begin
    rdPar = oddParity(rdData);
  end

  // Bus valid
  // One pulse per tagged word, two cycles after its ackn
  always_ff @(posedge mbus) begin
    if (reset) begin
      validIn <= 1'b0;
    end else begin
      validIn <= readTag;
    end
  end

  // Bus word and parity
  // Loaded only on tagged cycles, so back to back reads each get
  // their own word while the array already fetches the next one
  always_ff @(posedge mbus) begin
    if (readTag) begin
      dIn   <= rdData;
      parIn <= rdPar;
    end
  end

endmodule

// ==== verilog/coreArray.sv ====
// Core word array for the MB20 memory
// Single port storage with a registered read or a write each cycle

`timescale 1ns/1ps

module coreArray
  import memPkg::*;
#(
  parameter int memWords = 4096
) (
  input  logic    mbus,
  input  tArrayOp op,
  output tWord36  rdData
);

  // Index bits, address taken modulo memWords
  localparam int idxBits = $clog2(memWords);

  tWord36 mem [memWords];

  logic [idxBits-1:0] idx;

  always_comb begin
    idx = op.addr[idxBits-1:0];
  end

  // Core starts cleared
  initial begin
    for (int i = 0; i < memWords; i++) begin
      mem[i] = '0;
    end
  end

  // Write port
  always_ff @(posedge mbus) begin
    if (op.wrEn) begin
      mem[idx] <= op.wrData;
    end
  end

  // Registered read
  // rdData holds until the next read
  always_ff @(posedge mbus) begin
    if (op.rdEn) begin
      rdData <= mem[idx];
    end
  end

endmodule

// ==== verilog/wordSequencer.sv ====
// Word sequencer for the MB20 memory
// Walks the four quad slots, acknowledges requested words and
// issues reads and writes to the array

`timescale 1ns/1ps

module wordSequencer
  import memPkg::*;
(
  input  logic      mbus,
  input  logic      reset,
  input  tCycleDesc desc,
  input  tWord36    dOut,
  input  logic      validOut,
  output logic      ackn,
  output tArrayOp   op,
  output logic      readTag,
  output logic      done
);

  // Slot being handled this cycle
  logic [1:0] slot;

  // Wrapped address of the current slot
  tMemAddr curAddr;

  // Write acknowledged last cycle, waiting for validOut
  logic    pendWr;
  tMemAddr pendAddr;

  // Write commits only when the master supplies the word
  logic commitWr;

  // Read issued in the current slot
  logic issueRd;

  // Slot counter
  // Runs 0 to 3 while a descriptor is valid and wraps back to 0
  always_ff @(posedge mbus) begin
    if (reset) begin
      slot <= 2'd0;
    end else if (desc.valid) begin
      slot <= slot + 2'd1;
    end else begin
      slot <= 2'd0;
    end
  end

  always_comb begin
    curAddr = slotAddr(desc.adr, slot);
    // One ackn per set mask bit, in slot order
    ackn = desc.valid && desc.rq[slot];
    done = desc.valid && (slot == 2'd3);
    issueRd = ackn && !desc.isWrite;
    commitWr = pendWr && validOut;
  end

  // Pending write
  // The word follows ackn by one cycle, so hold the slot address
  always_ff @(posedge mbus) begin
    if (reset) begin
      pendWr <= 1'b0;
    end else begin
      pendWr <= ackn && desc.isWrite;
    end
  end

  always_ff @(posedge mbus) begin
    if (ackn) begin
      pendAddr <= curAddr;
    end
  end

  // Array port
  // A cycle is all reads or all writes, so the two never collide
  // within a cycle; the last write of a cycle lands before any
  // new slot 0 can run
  always_comb begin
    op.rdEn   = 1'b0;
    op.wrEn   = 1'b0;
    op.addr   = curAddr;
    op.wrData = dOut;
    if (commitWr) begin
      op.wrEn = 1'b1;
      op.addr = pendAddr;
    end else if (issueRd) begin
      op.rdEn = 1'b1;
    end
  end

  // Read word leaves the array one cycle after the read
  always_ff @(posedge mbus) begin
    if (reset) begin
      readTag <= 1'b0;
    end else begin
      readTag <= op.rdEn;
    end
  end

endmodule

// ==== verilog/cycleDecode.sv ====
// Start decode for the MB20 memory
// Captures a qualified start into a cycle descriptor, held until done

`timescale 1ns/1ps

module cycleDecode
  import memPkg::*;
(
  input  logic      mbus,
  input  logic      reset,
  input  logic      start,
  input  logic      rdRq,
  input  logic      wrRq,
  input  tRqMask    rq,
  input  tMemAddr   adr,
  input  logic      done,
  output tCycleDesc desc
);

  // Exactly one qualifier must go with start
  logic qualOk;

  // Start taken only while no cycle is running
  logic accept;

  // Descriptor fields held for the whole cycle
  logic    isWriteQ;
  tMemAddr adrQ;
  tRqMask  rqQ;
  logic    validQ;

  always_comb begin
    qualOk = rdRq ^ wrRq;
    accept = start && qualOk && !validQ;
  end

  // Busy flag
  // Set on accept, cleared when the sequencer finishes slot 3
  always_ff @(posedge mbus) begin
    if (reset) begin
      validQ <= 1'b0;
    end else if (accept) begin
      validQ <= 1'b1;
    end else if (done) begin
      validQ <= 1'b0;
    end
  end

  // Qualifier, address and mask captured with the start
  always_ff @(posedge mbus) begin
    if (accept) begin
      isWriteQ <= wrRq;
      adrQ     <= adr;
      rqQ      <= rq;
    end
  end

  always_comb begin
    desc.isWrite = isWriteQ;
    desc.adr     = adrQ;
    desc.rq      = rqQ;
    desc.valid   = validQ;
  end

endmodule

// ==== verilog/memPkg.sv ====
// MB20 memory package
// Word, address and cycle descriptor types for the memory slave

package memPkg;

  // One 36-bit memory word
  typedef logic [35:0] tWord36;

  // Word address, low two bits index the word within a quad
  typedef logic [21:0] tMemAddr;

  // Word request mask, bit 0 is the word at the start address
  typedef logic [3:0] tRqMask;

  // Cycle captured from the bus on an accepted start
  typedef struct packed {
    logic    isWrite;
    tMemAddr adr;
    tRqMask  rq;
    logic    valid;
  } tCycleDesc;

  // One access to the word array
  typedef struct packed {
    logic    rdEn;
    logic    wrEn;
    tMemAddr addr;
    tWord36  wrData;
  } tArrayOp;

  // Address of slot k, wrapping within the aligned quad
  function automatic tMemAddr slotAddr(tMemAddr startAdr, logic [1:0] k);
    tMemAddr a;
    a = startAdr;
    a[1:0] = startAdr[1:0] + k;
    return a;
  endfunction

  // Parity bit that makes the word plus parity odd
  function automatic logic oddParity(tWord36 w);
    return ~^w;
  endfunction

endpackage
